/* qeciphy_serdes.f */
+incdir+source
+incdir+verif
source/qeciphy_pkg.sv
source/qeciphy_tx_64b_to_32b.sv
source/qeciphy_lane_model.sv
source/qeciphy_rx_bytealigner.sv
source/qeciphy_rx_32b_to_64b.sv
source/qeciphy_serdes.sv
verif/qeciphy_serdes_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the QECIPHY SerDes testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module qeciphy_serdes_tb \
   -f qeciphy_serdes.f -Mdir obj_dir -o qeciphy_sim > build.log 2>&1 \
   && ./obj_dir/qeciphy_sim > sim.log 2>&1 \
   || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

/* verif/qeciphy_tb_scoreboard.svh */
// ==============================
// SerDes receive scoreboard
// ==============================

`ifndef QECIPHY_TB_SCOREBOARD_SVH
`define QECIPHY_TB_SCOREBOARD_SVH

task automatic clear_scoreboard();
   exp_q.delete();
   synced    = 1'b0;
   faw_seen  = 1'b0;
   since_faw = 0;
endtask

task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] got);
   $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
   error_count++;
endtask

task automatic check_flags_low();
   if (rx_byte_aligned_o !== 1'b0) begin
      report_value("rx_byte_aligned_o", 64'd0, {63'd0, rx_byte_aligned_o});
   end
   if (rx_align_fail_o !== 1'b0) begin
      report_value("rx_align_fail_o", 64'd0, {63'd0, rx_align_fail_o});
   end
   if (rx_aligned_o !== 1'b0) begin
      report_value("rx_aligned_o", 64'd0, {63'd0, rx_aligned_o});
   end
   if (rx_tvalid_o !== 1'b0) begin
      report_value("rx_tvalid_o", 64'd0, {63'd0, rx_tvalid_o});
   end
endtask

// Flag that must stay low for the whole row
task automatic check_row_flags();
   if (run_active && !flag_reported) begin
      if (expect_ok && rx_align_fail_o) begin
         report_value("rx_align_fail_o", 64'd0, 64'd1);
         flag_reported = 1'b1;
      end
      if (!expect_ok && rx_aligned_o) begin
         report_value("rx_aligned_o", 64'd0, 64'd1);
         flag_reported = 1'b1;
      end
   end
endtask

// Aligned rows must deliver both data and markers
task automatic require_rx_traffic();
   if (!synced) begin
      $display("No data word received after alignment by %0t", $time);
      error_count++;
   end
   if (!faw_seen) begin
      $display("No FAW word received after alignment by %0t", $time);
      error_count++;
   end
endtask

function automatic logic flag_value(input int sel);
   case (sel)
      0:       return rx_byte_aligned_o;
      1:       return rx_align_fail_o;
      default: return rx_aligned_o;
   endcase
endfunction

task automatic wait_flag_high(input int sel, input string name, input int max_cycles,
                              output int cycles);
   cycles = 0;
   while (!flag_value(sel) && cycles < max_cycles) begin
      @(negedge clk_i);
      cycles++;
   end
   if (!flag_value(sel)) begin
      $display("Timeout at %0t: %s did not rise within %0d cycles", $time, name, max_cycles);
      error_count++;
   end
endtask

task automatic check_rx_word(input logic [63:0] data);
   logic [63:0] expected;
   since_faw++;
   if (data == qeciphy_pkg::FAW_WORD) begin
      if (faw_seen && since_faw != PERIOD) begin
         report_value("rx_tdata_o FAW spacing", 64'(PERIOD), 64'(since_faw));
      end
      faw_seen  = 1'b1;
      since_faw = 0;
   end else begin
      if (!synced) begin
         while (exp_q.size() > 0 && exp_q[0] != data) begin
            expected = exp_q.pop_front();  // Sent before lock
         end
         synced = (exp_q.size() > 0);
         if (!synced) begin
            $display("Received word %h at %0t was never sent", data, $time);
            error_count++;
         end
      end
      if (synced) begin
         if (exp_q.size() == 0) begin
            $display("Received word %h at %0t with nothing left to match", data, $time);
            error_count++;
         end else begin
            expected = exp_q.pop_front();
            if (data !== expected) report_value("rx_tdata_o", expected, data);
         end
      end
   end
endtask

`endif

/* verif/qeciphy_serdes_tb.sv */
// ==============================
// QECIPHY SerDes testbench
// ==============================

`timescale 1ns/1ps
`include "qeciphy_defs.svh"
`default_nettype none

module qeciphy_serdes_tb;

   typedef struct packed {
      logic [1:0]  skew;       // Lane skew loaded at reset
      logic        markers;    // Send FAW every marker period
      logic [15:0] n_words;    // 64-bit words to send
      logic        expect_ok;  // Aligned when set, else fail
   } row_t;

   localparam int PERIOD = `QECIPHY_MARKER_PERIOD;

   logic        clk_i;
   logic        rst_n_i;
   logic [1:0]  lane_skew_i;
   logic [63:0] tx_tdata_i;
   logic        tx_tready_o;
   logic [63:0] rx_tdata_o;
   logic        rx_tvalid_o;
   logic        rx_byte_aligned_o;
   logic        rx_align_fail_o;
   logic        rx_aligned_o;

   row_t        rows [6];       // Scenario table
   logic [63:0] exp_q [$];      // Sent words awaiting receive
   int          error_count;
   bit          synced;         // First received word found in queue
   bit          faw_seen;
   int          since_faw;      // Valid words since last FAW
   bit          run_active;     // Stream running for current row
   bit          expect_ok;
   bit          flag_reported;  // One flag error per row

   `include "qeciphy_tb_scoreboard.svh"

   qeciphy_serdes dut_i (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .lane_skew_i      (lane_skew_i),
      .tx_tdata_i       (tx_tdata_i),
      .tx_tready_o      (tx_tready_o),
      .rx_tdata_o       (rx_tdata_o),
      .rx_tvalid_o      (rx_tvalid_o),
      .rx_byte_aligned_o(rx_byte_aligned_o),
      .rx_align_fail_o  (rx_align_fail_o),
      .rx_aligned_o     (rx_aligned_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;  // 40 ns lane clock
   end

   // Outputs settle well before the falling edge
   always @(negedge clk_i) begin
      if (rx_tvalid_o) begin
         check_rx_word(rx_tdata_o);
      end
      check_row_flags();
   end

   // Random data word with no comma in any byte
   function automatic logic [63:0] random_word();
      logic [63:0] w;
      w = {$urandom, $urandom};
      for (int b = 0; b < 8; b++) begin
         if (w[8*b +: 8] == qeciphy_pkg::COMMA_BYTE) begin
            w[8*b +: 8] = 8'h3C;
         end
      end
      return w;
   endfunction

   task automatic drive_stream(input bit markers, input int n_words);
      int          sent;
      int          cycles;
      logic        last_ready;
      logic [63:0] word;
      sent       = 0;
      cycles     = 0;
      last_ready = 1'b0;
      while (sent < n_words && cycles < 4 * n_words + 8) begin
         @(posedge clk_i);
         #2;
         cycles++;
         // Ready strobe alternates every cycle
         if (cycles > 1 && tx_tready_o === last_ready) begin
            report_value("tx_tready_o", {63'd0, ~last_ready}, {63'd0, tx_tready_o});
         end
         last_ready = tx_tready_o;
         if (tx_tready_o) begin
            if (markers && (sent % PERIOD == 0)) begin
               word = qeciphy_pkg::FAW_WORD;  // Marker word is not queued
            end else begin
               word = random_word();
               exp_q.push_back(word);
            end
            tx_tdata_i = word;
            sent++;
         end
      end
      if (sent < n_words) begin
         $display("Transmit stalled at %0t: only %0d of %0d words taken", $time, sent, n_words);
         error_count++;
      end
   endtask

   task automatic apply_reset(input logic [1:0] skew);
      @(posedge clk_i);
      #2;
      rst_n_i     = 1'b0;
      lane_skew_i = skew;  // New line skew
      clear_scoreboard();
      repeat (16) begin
         @(negedge clk_i);
         check_flags_low();
         if (tx_tready_o !== 1'b0) begin
            report_value("tx_tready_o", 64'd0, {63'd0, tx_tready_o});
         end
      end
      @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      repeat (2) begin
         @(negedge clk_i);
         check_flags_low();  // First cycles after release
      end
   endtask

   // Limits count from reset release less two cycles already spent
   task automatic check_alignment(input bit ok_expected);
      int used;
      int used_word;
      if (ok_expected) begin
         wait_flag_high(0, "rx_byte_aligned_o", 6 * PERIOD * 2 - 2, used);
         wait_flag_high(2, "rx_aligned_o", 6 * PERIOD * 2 - 2 - used, used_word);
      end else begin
         wait_flag_high(1, "rx_align_fail_o", `QECIPHY_ALIGN_TIMEOUT + 8 - 2, used);
         if (rx_aligned_o !== 1'b0) begin
            report_value("rx_aligned_o", 64'd0, {63'd0, rx_aligned_o});
         end
      end
   endtask

   initial begin
      rst_n_i       = 1'b0;
      lane_skew_i   = 2'd0;
      tx_tdata_i    = 64'd0;
      error_count   = 0;
      run_active    = 1'b0;
      expect_ok     = 1'b1;
      flag_reported = 1'b0;
      void'($urandom(33));  // Fixed seed for the run
      rows[0] = '{skew: 2'd0, markers: 1'b1, n_words: 16'd200, expect_ok: 1'b1};
      rows[1] = '{skew: 2'd1, markers: 1'b1, n_words: 16'd200, expect_ok: 1'b1};
      rows[2] = '{skew: 2'd2, markers: 1'b0, n_words: 16'd50, expect_ok: 1'b0};
      rows[3] = '{skew: 2'd2, markers: 1'b1, n_words: 16'd200, expect_ok: 1'b1};
      rows[4] = '{skew: 2'd3, markers: 1'b1, n_words: 16'd200, expect_ok: 1'b1};
      rows[5] = '{skew: 2'd1, markers: 1'b1, n_words: 16'd200, expect_ok: 1'b1};
      for (int r = 0; r < 6; r++) begin
         $display("Scenario %0d: skew %0d markers %0d", r, rows[r].skew, rows[r].markers);
         apply_reset(rows[r].skew);  // Mid-stream when previous row aligned
         expect_ok     = rows[r].expect_ok;
         flag_reported = 1'b0;
         run_active    = 1'b1;
         fork
            drive_stream(rows[r].markers, int'(rows[r].n_words));
            check_alignment(rows[r].expect_ok);
         join
         if (rows[r].expect_ok) begin
            require_rx_traffic();
         end
         run_active = 1'b0;
      end
      $display("Run complete with %0d errors", error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* source/qeciphy_serdes.sv */
// ==============================
// QECIPHY SerDes top
// ==============================

`timescale 1ns/1ps
`default_nettype none

module qeciphy_serdes (
   input  logic        clk_i,              // Lane-rate clock
   input  logic        rst_n_i,            // Async reset, active low
   input  logic [1:0]  lane_skew_i,        // Line byte skew
   input  logic [63:0] tx_tdata_i,         // 64-bit TX word
   output logic        tx_tready_o,        // TX word taken
   output logic [63:0] rx_tdata_o,         // 64-bit RX word
   output logic        rx_tvalid_o,        // RX word valid
   output logic        rx_byte_aligned_o,  // Comma aligned
   output logic        rx_align_fail_o,    // Comma search failed
   output logic        rx_aligned_o        // FAW aligned
);

   qeciphy_pkg::lane_word_t tx_lane;    // TX stage to line
   qeciphy_pkg::lane_word_t line_lane;  // Line to byte aligner
   qeciphy_pkg::lane_word_t rx_lane;    // Byte aligned words
   logic                    slide;
   logic                    slide_rdy;
   logic                    byte_done;
   logic                    word_rst_n;  // Word aligner runs after byte lock

   assign word_rst_n        = rst_n_i & byte_done;
   assign rx_byte_aligned_o = byte_done;

   // ==============================
   // TX and line
   // ==============================
   qeciphy_tx_64b_to_32b i_tx_64b_to_32b (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .tx_tdata_i (tx_tdata_i),
      .tx_tready_o(tx_tready_o),
      .lane_o     (tx_lane)
   );

   qeciphy_lane_model i_lane_model (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .lane_skew_i(lane_skew_i),
      .lane_i     (tx_lane),
      .slide_i    (slide),
      .lane_o     (line_lane),
      .slide_rdy_o(slide_rdy)
   );

   // ==============================
   // RX alignment
   // ==============================
   qeciphy_rx_bytealigner i_rx_bytealigner (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .lane_i      (line_lane),
      .slide_rdy_i (slide_rdy),
      .slide_o     (slide),
      .lane_o      (rx_lane),
      .align_done_o(byte_done),
      .align_fail_o(rx_align_fail_o)
   );

   qeciphy_rx_32b_to_64b i_rx_32b_to_64b (
      .clk_i      (clk_i),
      .rst_n_i    (word_rst_n),  // Held in reset until byte aligned
      .lane_i     (rx_lane),
      .tdata_64b_o(rx_tdata_o),
      .tvalid_o   (rx_tvalid_o),
      .aligned_o  (rx_aligned_o)
   );

endmodule

`default_nettype wire

/* source/qeciphy_rx_32b_to_64b.sv */
// ==============================
// RX FAW word aligner
// ==============================

`timescale 1ns/1ps
`default_nettype none

module qeciphy_rx_32b_to_64b (
   input  logic                    clk_i,        // Lane-rate clock
   input  logic                    rst_n_i,      // Held low until byte aligned
   input  qeciphy_pkg::lane_word_t lane_i,       // Byte-aligned lane word
   output logic [63:0]             tdata_64b_o,  // Rebuilt protocol word
   output logic                    tvalid_o,     // One pulse per word pair
   output logic                    aligned_o     // Word phase locked
);

   qeciphy_pkg::word_align_state_e state_q;
   logic        phase_q;   // High when lane_i is the upper half
   logic        tvalid_q;
   logic [31:0] prev_q;    // Previous lane word
   logic [63:0] pair;      // Current word over previous
   logic [63:0] tdata_q;
   logic        faw_hit;

   assign pair    = {lane_i.data, prev_q};
   assign faw_hit = lane_i.valid && (pair == qeciphy_pkg::FAW_WORD);

   // ==============================
   // Phase FSM
   // ==============================
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= qeciphy_pkg::HUNT;
         phase_q  <= 1'b0;
         tvalid_q <= 1'b0;
      end else begin
         tvalid_q <= 1'b0;
         if (lane_i.valid) begin
            phase_q <= ~phase_q;  // Alternate low and high halves
            case (state_q)
               qeciphy_pkg::HUNT: if (faw_hit) begin
                  // FAW on the low slot means halves are swapped
                  state_q <= phase_q ? qeciphy_pkg::LOCKED : qeciphy_pkg::FLIP;
               end
               qeciphy_pkg::FLIP: begin
                  phase_q <= phase_q;  // Skip one toggle
                  state_q <= qeciphy_pkg::HUNT;
               end
               qeciphy_pkg::LOCKED: begin
                  tvalid_q <= phase_q;  // Emit on upper half
                  if (faw_hit && !phase_q) begin
                     state_q <= qeciphy_pkg::HUNT;  // Phase lost
                  end
               end
               default: state_q <= qeciphy_pkg::HUNT;
            endcase
         end
      end
   end

   // Word data path
   always_ff @(posedge clk_i) begin
      if (lane_i.valid) begin
         prev_q  <= lane_i.data;
         tdata_q <= pair;
      end
   end

   assign tdata_64b_o = tdata_q;
   assign tvalid_o    = tvalid_q;
   assign aligned_o   = (state_q == qeciphy_pkg::LOCKED);

endmodule

`default_nettype wire

/* source/qeciphy_rx_bytealigner.sv */
// ==============================
// RX comma byte aligner
// ==============================

`timescale 1ns/1ps
`include "qeciphy_defs.svh"
`default_nettype none

module qeciphy_rx_bytealigner (
   input  logic                    clk_i,         // Lane-rate clock
   input  logic                    rst_n_i,       // Async reset, active low
   input  qeciphy_pkg::lane_word_t lane_i,        // Word from the lane
   input  logic                    slide_rdy_i,   // Lane ready for a slide
   output logic                    slide_o,       // One-cycle slide request
   output qeciphy_pkg::lane_word_t lane_o,        // Registered pass-through
   output logic                    align_done_o,  // Comma locked in lane 0
   output logic                    align_fail_o   // Gave up on commas
);

   localparam int TIMEOUT = `QECIPHY_ALIGN_TIMEOUT;
   localparam int MISS_W  = $clog2(TIMEOUT);

   qeciphy_pkg::byte_align_state_e state_q;
   logic [MISS_W-1:0] miss_cnt_q;     // Words since last comma
   logic [1:0]        slides_left_q;  // Slides still to issue
   logic [3:0]        comma_hit;      // Comma per byte lane
   logic [1:0]        comma_lane;     // Lowest lane with a comma
   logic              miss_out;       // Timeout reached
   logic              valid_q;
   logic [31:0]       data_q;

   // ==============================
   // Comma detect
   // ==============================
   always_comb begin
      comma_lane = 2'd0;
      for (int i = 0; i < 4; i++) begin
         comma_hit[i] = (lane_i.data[8*i +: 8] == qeciphy_pkg::COMMA_BYTE);
      end
      for (int i = 3; i >= 0; i--) begin
         if (comma_hit[i]) begin
            comma_lane = 2'(i);
         end
      end
   end

   assign miss_out = (miss_cnt_q == MISS_W'(TIMEOUT - 1));

   // ==============================
   // Alignment FSM
   // ==============================
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q       <= qeciphy_pkg::SEARCH;
         miss_cnt_q    <= '0;
         slides_left_q <= '0;
      end else begin
         case (state_q)
            qeciphy_pkg::SEARCH: if (lane_i.valid) begin
               if (comma_hit[0]) begin
                  state_q    <= qeciphy_pkg::CONFIRM;  // Already aligned
                  miss_cnt_q <= '0;
               end else if (|comma_hit) begin
                  state_q       <= qeciphy_pkg::SLIDE;
                  slides_left_q <= 2'd0 - comma_lane;  // Slides to reach lane 0
               end else if (miss_out) begin
                  state_q <= qeciphy_pkg::FAIL;
               end else begin
                  miss_cnt_q <= miss_cnt_q + 1'b1;
               end
            end
            qeciphy_pkg::SLIDE: begin
               slides_left_q <= slides_left_q - 2'd1;
               state_q       <= qeciphy_pkg::WAIT_RDY;
            end
            qeciphy_pkg::WAIT_RDY: if (slide_rdy_i) begin
               if (slides_left_q != 2'd0) begin
                  state_q <= qeciphy_pkg::SLIDE;  // More bytes to shift
               end else begin
                  state_q    <= qeciphy_pkg::SEARCH;
                  miss_cnt_q <= '0;
               end
            end
            qeciphy_pkg::CONFIRM: if (lane_i.valid) begin
               if (comma_hit[0]) begin
                  state_q <= qeciphy_pkg::DONE;  // Second comma agrees
               end else if (|comma_hit) begin
                  state_q    <= qeciphy_pkg::SEARCH;  // Lane moved
                  miss_cnt_q <= '0;
               end else if (miss_out) begin
                  state_q <= qeciphy_pkg::FAIL;
               end else begin
                  miss_cnt_q <= miss_cnt_q + 1'b1;
               end
            end
            default: state_q <= state_q;  // DONE and FAIL hold
         endcase
      end
   end

   // Pass-through register
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= lane_i.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      data_q <= lane_i.data;
   end

   assign slide_o      = (state_q == qeciphy_pkg::SLIDE);
   assign align_done_o = (state_q == qeciphy_pkg::DONE);
   assign align_fail_o = (state_q == qeciphy_pkg::FAIL);
   assign lane_o       = '{data: data_q, valid: valid_q};

endmodule

`default_nettype wire

/* source/qeciphy_lane_model.sv */
// ==============================
// Behavioral loopback lane
// ==============================

`timescale 1ns/1ps
`include "qeciphy_defs.svh"
`default_nettype none

module qeciphy_lane_model (
   input  logic                    clk_i,        // Lane-rate clock
   input  logic                    rst_n_i,      // Async reset, active low
   input  logic [1:0]              lane_skew_i,  // Byte skew loaded at reset
   input  qeciphy_pkg::lane_word_t lane_i,       // From TX stage
   input  logic                    slide_i,      // Slide request from RX
   output qeciphy_pkg::lane_word_t lane_o,       // Skewed word to RX
   output logic                    slide_rdy_o   // Low while slide settles
);

   localparam int SLIDE_WAIT = `QECIPHY_SLIDE_WAIT;
   localparam int CNT_W      = $clog2(SLIDE_WAIT + 1);

   logic [1:0]       skew_q;     // Current byte offset
   logic [CNT_W-1:0] rdy_cnt_q;  // Slide recovery countdown
   logic             valid_q;
   logic [31:0]      prev_q;     // Previous line word for byte history
   logic [31:0]      data_q;
   logic [31:0]      shifted;    // Four bytes at skew offset

   // ==============================
   // Byte barrel
   // ==============================
   always_comb begin
      case (skew_q)
         2'd0:    shifted = lane_i.data;                          // No delay
         2'd1:    shifted = {lane_i.data[23:0], prev_q[31:24]};   // One byte late
         2'd2:    shifted = {lane_i.data[15:0], prev_q[31:16]};   // Two bytes late
         default: shifted = {lane_i.data[7:0], prev_q[31:8]};     // Three bytes late
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         skew_q    <= lane_skew_i;  // Unknown line skew
         rdy_cnt_q <= '0;
         valid_q   <= 1'b0;
      end else begin
         valid_q <= lane_i.valid;
         if (slide_i && slide_rdy_o) begin
            skew_q    <= skew_q + 2'd1;       // Wraps modulo 4
            rdy_cnt_q <= CNT_W'(SLIDE_WAIT);  // Start recovery
         end else if (rdy_cnt_q != '0) begin
            rdy_cnt_q <= rdy_cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (lane_i.valid) begin
         prev_q <= lane_i.data;  // Keep for cross-word bytes
      end
      data_q <= shifted;
   end

   assign slide_rdy_o = (rdy_cnt_q == '0);
   assign lane_o      = '{data: data_q, valid: valid_q};

endmodule

`default_nettype wire

/* source/qeciphy_tx_64b_to_32b.sv */
// ==============================
// TX 64b to 32b splitter
// ==============================

`timescale 1ns/1ps
`default_nettype none

module qeciphy_tx_64b_to_32b (
   input  logic                    clk_i,        // Lane-rate clock
   input  logic                    rst_n_i,      // Async reset, active low
   input  logic [63:0]             tx_tdata_i,   // Protocol word
   output logic                    tx_tready_o,  // Word taken this cycle
   output qeciphy_pkg::lane_word_t lane_o        // Lane word to the line
);

   logic        ready_q;  // Phase flop, high on capture cycles
   logic        valid_q;  // Set after first capture
   logic [31:0] data_q;   // Lane word being sent
   logic [31:0] hi_q;     // Upper half waits one cycle

   // ==============================
   // Phase and valid
   // ==============================
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ready_q <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         ready_q <= ~ready_q;  // Toggle every cycle
         if (ready_q) begin
            valid_q <= 1'b1;  // Stream runs from here on
         end
      end
   end

   // Low half right after capture, high half next
   always_ff @(posedge clk_i) begin
      if (ready_q) begin
         data_q <= tx_tdata_i[31:0];   // Low half goes first
         hi_q   <= tx_tdata_i[63:32];  // Hold upper half
      end else begin
         data_q <= hi_q;
      end
   end

   assign tx_tready_o = ready_q;
   assign lane_o      = '{data: data_q, valid: valid_q};

endmodule

`default_nettype wire

/* source/qeciphy_pkg.sv */
// ==============================
// QECIPHY SerDes shared types
// ==============================

`default_nettype none

package qeciphy_pkg;

   // Lane word passed between SerDes stages
   typedef struct packed {
      logic [31:0] data;   // Four bytes with byte 0 first on the line
      logic        valid;  // Word present this cycle
   } lane_word_t;

   // Byte aligner FSM states
   typedef enum logic [2:0] {
      SEARCH,    // Scan all byte lanes for a comma
      SLIDE,     // One-cycle slide request
      WAIT_RDY,  // Lane recovering from slide
      CONFIRM,   // Await second comma in lane 0
      DONE,      // Byte aligned, held until reset
      FAIL       // No comma found in time
   } byte_align_state_e;

   // Word aligner FSM states
   typedef enum logic [1:0] {
      HUNT,    // Look for FAW at either phase
      LOCKED,  // Phase known, emit pairs
      FLIP     // Skip one phase toggle
   } word_align_state_e;

   localparam logic [7:0]  COMMA_BYTE = 8'hBC;
   // Low lane word carries the comma in byte 0 and the high word none
   localparam logic [63:0] FAW_WORD   = 64'h5A3C_96E1_4F2D_71BC;

endpackage

`default_nettype wire

/* source/qeciphy_defs.svh */
// ==============================
// QECIPHY SerDes constants
// ==============================

`ifndef QECIPHY_DEFS_SVH
`define QECIPHY_DEFS_SVH

`default_nettype none

// 64-bit words between frame alignment words
`define QECIPHY_MARKER_PERIOD 16

// Lane words without comma before byte alignment gives up
`define QECIPHY_ALIGN_TIMEOUT (4 * `QECIPHY_MARKER_PERIOD)

// Cycles slide-ready stays low after a slide
`define QECIPHY_SLIDE_WAIT 4

`default_nettype wire

`endif
